/* rtl/seg_pkg.sv */
`default_nettype none

package seg_pkg;

    // ~~~~~~~~~~~~ Character codes ~~~~~~~~~~~~
    typedef logic [5:0] char_code_t;

    typedef enum logic [5:0] {
        CHAR_0          = 6'd0,
        CHAR_1          = 6'd1,
        CHAR_2          = 6'd2,
        CHAR_3          = 6'd3,
        CHAR_4          = 6'd4,
        CHAR_5          = 6'd5,
        CHAR_6          = 6'd6,
        CHAR_7          = 6'd7,
        CHAR_8          = 6'd8,
        CHAR_9          = 6'd9,
        CHAR_A          = 6'd10,
        CHAR_B          = 6'd11,
        CHAR_C          = 6'd12,
        CHAR_D          = 6'd13,
        CHAR_E          = 6'd14,
        CHAR_F          = 6'd15,
        CHAR_G          = 6'd16,  // Letters follow the hex digits.
        CHAR_H          = 6'd17,
        CHAR_I          = 6'd18,
        CHAR_J          = 6'd19,
        CHAR_K          = 6'd20,
        CHAR_L          = 6'd21,
        CHAR_M          = 6'd22,
        CHAR_N          = 6'd23,
        CHAR_O          = 6'd24,
        CHAR_P          = 6'd25,
        CHAR_Q          = 6'd26,
        CHAR_R          = 6'd27,
        CHAR_S          = 6'd28,
        CHAR_T          = 6'd29,
        CHAR_U          = 6'd30,
        CHAR_V          = 6'd31,
        CHAR_Y          = 6'd32,
        CHAR_Z          = 6'd33,
        CHAR_SPACE      = 6'd34,  // Symbols follow the letters. Higher codes are blank.
        CHAR_MINUS      = 6'd35,
        CHAR_UNDERSCORE = 6'd36,
        CHAR_EQUALS     = 6'd37,
        CHAR_DEGREE     = 6'd38
    } char_code_e;

    // ~~~~~~~~~~~~ Segment and digit words ~~~~
    typedef struct packed {
        logic a;
        logic b;
        logic c;
        logic d;
        logic e;
        logic f;
        logic g;
        logic dp;
    } seg_pattern_t;  // A 1 lights the segment.

    typedef struct packed {
        logic       raw_mode;
        logic       spare;
        logic       dp;
        char_code_t code;
    } digit_glyph_t;

    typedef struct packed {
        logic         raw_mode;
        seg_pattern_t segs;
    } digit_raw_t;

    typedef union packed {
        digit_glyph_t glyph;
        digit_raw_t   raw;
    } digit_reg_u;  // The raw_mode bit selects the member.

    // ~~~~~~~~~~~~ APB ~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    localparam logic [7:0]  DIGIT_BASE_ADDR = 8'h00;  // Digit k sits at 4*k.
    localparam logic [7:0]  CTRL_ADDR       = 8'h20;
    localparam logic [7:0]  PRESCALE_ADDR   = 8'h24;
    localparam logic [15:0] PRESCALE_RESET  = 16'd3;

endpackage

`default_nettype wire

/* rtl/seg_glyph_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module seg_glyph_decoder import seg_pkg::*; (
    input  char_code_t   code_i,
    output seg_pattern_t pattern_o
);

    logic [6:0] abcdefg;

    // ~~~~~~~~~~~~ Character table ~~~~~~~~~~~~
    always_comb begin
        case (code_i)
            CHAR_0:          abcdefg = 7'b1111110;
            CHAR_1:          abcdefg = 7'b0110000;
            CHAR_2:          abcdefg = 7'b1101101;
            CHAR_3:          abcdefg = 7'b1111001;
            CHAR_4:          abcdefg = 7'b0110011;
            CHAR_5:          abcdefg = 7'b1011011;
            CHAR_6:          abcdefg = 7'b1011111;
            CHAR_7:          abcdefg = 7'b1110000;
            CHAR_8:          abcdefg = 7'b1111111;
            CHAR_9:          abcdefg = 7'b1111011;
            CHAR_A:          abcdefg = 7'b1110111;
            CHAR_B:          abcdefg = 7'b0011111;  // Lower case b.
            CHAR_C:          abcdefg = 7'b1001110;
            CHAR_D:          abcdefg = 7'b0111101;  // Lower case d.
            CHAR_E:          abcdefg = 7'b1001111;
            CHAR_F:          abcdefg = 7'b1000111;
            CHAR_G:          abcdefg = 7'b1011110;
            CHAR_H:          abcdefg = 7'b0110111;
            CHAR_I:          abcdefg = 7'b0000110;
            CHAR_J:          abcdefg = 7'b0111000;
            CHAR_K:          abcdefg = 7'b1010111;
            CHAR_L:          abcdefg = 7'b0001110;
            CHAR_M:          abcdefg = 7'b1110110;
            CHAR_N:          abcdefg = 7'b0010101;
            CHAR_O:          abcdefg = 7'b1111110;  // Same shape as 0.
            CHAR_P:          abcdefg = 7'b1100111;
            CHAR_Q:          abcdefg = 7'b1110011;
            CHAR_R:          abcdefg = 7'b0000101;
            CHAR_S:          abcdefg = 7'b1011011;  // Same shape as 5.
            CHAR_T:          abcdefg = 7'b0001111;
            CHAR_U:          abcdefg = 7'b0111110;
            CHAR_V:          abcdefg = 7'b0011100;
            CHAR_Y:          abcdefg = 7'b0111011;
            CHAR_Z:          abcdefg = 7'b1101101;  // Same shape as 2.
            CHAR_SPACE:      abcdefg = 7'b0000000;
            CHAR_MINUS:      abcdefg = 7'b0000001;
            CHAR_UNDERSCORE: abcdefg = 7'b0001000;
            CHAR_EQUALS:     abcdefg = 7'b0001001;
            CHAR_DEGREE:     abcdefg = 7'b1100011;
            default:         abcdefg = 7'b0000000;  // Unassigned codes stay dark.
        endcase
    end

    // The decimal point belongs to the digit register, not the character.
    assign pattern_o = {abcdefg, 1'b0};

endmodule

`default_nettype wire

/* rtl/seg_apb_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module seg_apb_regs import seg_pkg::*; #(
    parameter int N_DIGITS = 8
) (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  apb_req_t                  apb_req_i,
    output apb_rsp_t                  apb_rsp_o,
    output digit_reg_u [N_DIGITS-1:0] digits_o,
    output logic                      scan_en_o,
    output logic [N_DIGITS-1:0]       blank_mask_o,
    output logic [15:0]               prescale_o
);

    localparam int DIGIT_SPAN = N_DIGITS * 4;

    logic                      access;
    logic                      aligned;
    logic [7:0]                digit_off;
    logic [2:0]                digit_idx;
    logic                      sel_digit;
    logic                      sel_ctrl;
    logic                      sel_prescale;
    logic                      addr_ok;
    logic                      wr_en;
    logic [31:0]               rd_data;

    digit_reg_u [N_DIGITS-1:0] digit_q;
    logic                      enable_q;
    logic                      restart_q;
    logic [N_DIGITS-1:0]       blank_q;
    logic [15:0]               prescale_q;

    // ~~~~~~~~~~~~ Address decode ~~~~~~~~~~~~~
    assign access       = apb_req_i.psel & apb_req_i.penable;
    assign aligned      = (apb_req_i.paddr[1:0] == 2'b00);
    assign digit_off    = apb_req_i.paddr - DIGIT_BASE_ADDR;  // Wraps high below the base.
    assign digit_idx    = digit_off[4:2];
    assign sel_digit    = aligned && (32'(digit_off) < DIGIT_SPAN);
    assign sel_ctrl     = (apb_req_i.paddr == CTRL_ADDR);
    assign sel_prescale = (apb_req_i.paddr == PRESCALE_ADDR);
    assign addr_ok      = sel_digit | sel_ctrl | sel_prescale;
    assign wr_en        = access & apb_req_i.pwrite & addr_ok;

    // ~~~~~~~~~~~~ Register storage ~~~~~~~~~~~
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            digit_q    <= '0;
            enable_q   <= 1'b0;
            restart_q  <= 1'b0;
            blank_q    <= '0;
            prescale_q <= PRESCALE_RESET;
        end else begin
            restart_q <= wr_en & sel_ctrl;  // Any CTRL write restarts the scan.
            if (wr_en && sel_ctrl) begin
                enable_q <= apb_req_i.pwdata[0];
                blank_q  <= apb_req_i.pwdata[8 +: N_DIGITS];
            end
            if (wr_en && sel_prescale) begin
                prescale_q <= apb_req_i.pwdata[15:0];
            end
            for (int i = 0; i < N_DIGITS; i++) begin
                if (wr_en && sel_digit && (digit_idx == 3'(i))) begin
                    digit_q[i] <= apb_req_i.pwdata[8:0];
                end
            end
        end
    end

    // ~~~~~~~~~~~~ Read path ~~~~~~~~~~~~~~~~~~
    always_comb begin
        rd_data = '0;
        if (sel_ctrl) begin
            rd_data[0]            = enable_q;
            rd_data[8 +: N_DIGITS] = blank_q;
        end else if (sel_prescale) begin
            rd_data[15:0] = prescale_q;
        end else if (sel_digit) begin
            for (int i = 0; i < N_DIGITS; i++) begin
                if (digit_idx == 3'(i)) begin
                    rd_data[8:0] = digit_q[i];
                end
            end
        end
    end

    assign apb_rsp_o.prdata  = rd_data;  // Bad addresses fall through to zero.
    assign apb_rsp_o.pready  = 1'b1;
    assign apb_rsp_o.pslverr = access & ~addr_ok;

    // The restart cycle looks like a disable to the scan logic.
    assign scan_en_o    = enable_q & ~restart_q;
    assign digits_o     = digit_q;
    assign blank_mask_o = blank_q;
    assign prescale_o   = prescale_q;

endmodule

`default_nettype wire

/* rtl/seg_scan_mux.sv */
`timescale 1ns/1ns
`default_nettype none

module seg_scan_mux import seg_pkg::*; #(
    parameter int N_DIGITS   = 8,
    parameter int PRESCALE_W = 16
) (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  digit_reg_u [N_DIGITS-1:0] digits_i,
    input  logic                      scan_en_i,
    input  logic [N_DIGITS-1:0]       blank_mask_i,
    input  logic [PRESCALE_W-1:0]     prescale_i,
    output logic [N_DIGITS-1:0]       an_o,
    output seg_pattern_t              seg_n_o
);

    localparam int               IDX_W    = (N_DIGITS > 1) ? $clog2(N_DIGITS) : 1;
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(N_DIGITS - 1);

    logic [PRESCALE_W-1:0] tick_cnt_q;
    logic [IDX_W-1:0]      idx_q;
    digit_reg_u            cur_word;
    seg_pattern_t          glyph_pat;
    seg_pattern_t          lit_pat;
    logic                  blanked;

    // ~~~~~~~~~~~~ Digit sequencing ~~~~~~~~~~~
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || !scan_en_i) begin
            tick_cnt_q <= '0;
            idx_q      <= '0;
        end else if (tick_cnt_q >= prescale_i) begin  // Also catches a shrunk prescale.
            tick_cnt_q <= '0;
            idx_q      <= (idx_q == LAST_IDX) ? '0 : idx_q + 1'b1;
        end else begin
            tick_cnt_q <= tick_cnt_q + 1'b1;
        end
    end

    assign cur_word = digits_i[idx_q];

    seg_glyph_decoder u_glyph (
        .code_i    (cur_word.glyph.code),
        .pattern_o (glyph_pat)
    );

    always_comb begin
        if (cur_word.raw.raw_mode) begin
            lit_pat = cur_word.raw.segs;
        end else begin
            lit_pat    = glyph_pat;
            lit_pat.dp = cur_word.glyph.dp;
        end
    end

    assign blanked = !scan_en_i || blank_mask_i[idx_q];

    // ~~~~~~~~~~~~ Pin drive ~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || blanked) begin
            an_o    <= '1;  // All digits and segments dark.
            seg_n_o <= '1;
        end else begin
            an_o    <= ~(N_DIGITS'(1) << idx_q);
            seg_n_o <= ~lit_pat;
        end
    end

endmodule

`default_nettype wire

/* rtl/seg_display_top.sv */
`timescale 1ns/1ns
`default_nettype none

module seg_display_top import seg_pkg::*; #(
    parameter int N_DIGITS   = 8,
    parameter int PRESCALE_W = 16
) (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  apb_req_t            apb_req_i,
    output apb_rsp_t            apb_rsp_o,
    output logic [N_DIGITS-1:0] an_o,
    output seg_pattern_t        seg_n_o
);

    digit_reg_u [N_DIGITS-1:0] digits;
    logic                      scan_en;
    logic [N_DIGITS-1:0]       blank_mask;
    logic [15:0]               prescale;  // Register width is fixed by the memory map.

    // ~~~~~~~~~~~~ CPU side ~~~~~~~~~~~~~~~~~~~
    seg_apb_regs #(
        .N_DIGITS (N_DIGITS)
    ) u_regs (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .apb_req_i    (apb_req_i),
        .apb_rsp_o    (apb_rsp_o),
        .digits_o     (digits),
        .scan_en_o    (scan_en),
        .blank_mask_o (blank_mask),
        .prescale_o   (prescale)
    );

    // ~~~~~~~~~~~~ Display side ~~~~~~~~~~~~~~~
    // Only the low PRESCALE_W bits reach the counter.
    seg_scan_mux #(
        .N_DIGITS   (N_DIGITS),
        .PRESCALE_W (PRESCALE_W)
    ) u_scan (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .digits_i     (digits),
        .scan_en_i    (scan_en),
        .blank_mask_i (blank_mask),
        .prescale_i   (prescale[PRESCALE_W-1:0]),
        .an_o         (an_o),
        .seg_n_o      (seg_n_o)
    );

endmodule

`default_nettype wire

/* verif/tb_seg_display.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_seg_display import seg_pkg::*; ();

    localparam int         N_DIG    = 8;
    localparam logic [7:0] BAD_ADDR = 8'h30;

    // Lit segments a to g for codes 0 to 38.
    localparam logic [6:0] GLYPH_TBL [39] = '{
        7'h7e, 7'h30, 7'h6d, 7'h79, 7'h33, 7'h5b, 7'h5f, 7'h70,  // 0 to 7.
        7'h7f, 7'h7b, 7'h77, 7'h1f, 7'h4e, 7'h3d, 7'h4f, 7'h47,  // 8 to F.
        7'h5e, 7'h37, 7'h06, 7'h38, 7'h57, 7'h0e, 7'h76, 7'h15,  // G to N.
        7'h7e, 7'h67, 7'h73, 7'h05, 7'h5b, 7'h0f, 7'h3e, 7'h1c,  // O to V.
        7'h3b, 7'h6d,
        7'h00, 7'h01, 7'h08, 7'h09, 7'h63                        // Symbols.
    };

    logic         clk;
    logic         rst_n;
    apb_req_t     req;
    apb_rsp_t     rsp;
    logic [7:0]   an;
    seg_pattern_t seg_n;
    int           errors;
    int           checks;
    integer       seed;

    seg_display_top u_dut (
        .clk_i     (clk),
        .rst_n_i   (rst_n),
        .apb_req_i (req),
        .apb_rsp_o (rsp),
        .an_o      (an),
        .seg_n_o   (seg_n)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ~~~~~~~~~~~~ Helpers ~~~~~~~~~~~~~~~~~~~~
    task automatic next_cycle();
        @(posedge clk);
        #1;  // Drive and sample just after the edge.
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    function automatic logic [7:0] anode_for(input int k);
        return ~(8'(1) << k);
    endfunction

    function automatic logic [7:0] glyph_pins(input logic [5:0] code, input logic dp);
        logic [6:0] lit;
        lit = (code < 6'd39) ? GLYPH_TBL[code] : 7'h00;
        return ~{lit, dp};
    endfunction

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        req.psel    = 1'b1;
        req.penable = 1'b0;
        req.pwrite  = 1'b1;
        req.paddr   = addr;
        req.pwdata  = data;
        next_cycle();
        req.penable = 1'b1;
        next_cycle();
        req = '0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
        req.psel    = 1'b1;
        req.penable = 1'b0;
        req.pwrite  = 1'b0;
        req.paddr   = addr;
        req.pwdata  = '0;
        next_cycle();
        req.penable = 1'b1;
        #2;
        data = rsp.prdata;
        err  = rsp.pslverr;
        check("pready", 32'(rsp.pready), 32'h1);
        next_cycle();
        req = '0;
    endtask

    task automatic read_expect(input logic [7:0] addr, input string name,
                               input logic [31:0] exp);
        logic [31:0] data;
        logic        err;
        apb_read(addr, data, err);
        check(name, data, exp);
        check("pslverr", 32'(err), 32'h0);
    endtask

    task automatic wait_digit(input int k);
        int cycles;
        cycles = 0;
        while (an !== anode_for(k) && cycles < 2000) begin
            next_cycle();
            cycles++;
        end
        if (an !== anode_for(k)) begin
            errors++;
            $display("timed out waiting for the anode of digit %0d", k);
        end
    endtask

    // ~~~~~~~~~~~~ Tests ~~~~~~~~~~~~~~~~~~~~~~
    task automatic test_reset_state();
        logic [31:0] data;
        logic        err;
        check("an_o", 32'(an), 32'hff);
        check("seg_n_o", 32'(seg_n), 32'hff);
        read_expect(CTRL_ADDR, "ctrl", 32'h0);
        read_expect(PRESCALE_ADDR, "prescale", 32'(PRESCALE_RESET));
        apb_read(BAD_ADDR, data, err);
        check("pslverr", 32'(err), 32'h1);
        check("prdata", data, 32'h0);
    endtask

    task automatic test_register_access();
        logic [8:0]  words [8];
        logic [31:0] rnd;
        for (int i = 0; i < N_DIG; i++) begin
            rnd      = $random(seed);
            words[i] = rnd[8:0];
            apb_write(DIGIT_BASE_ADDR + 8'(4 * i), 32'(words[i]));
        end
        for (int i = 0; i < N_DIG; i++) begin
            read_expect(DIGIT_BASE_ADDR + 8'(4 * i), "digit", 32'(words[i]));
        end
        apb_write(CTRL_ADDR, 32'hffff_ffff);
        read_expect(CTRL_ADDR, "ctrl", 32'h0000_ff01);
        apb_write(CTRL_ADDR, 32'h0);
        apb_write(PRESCALE_ADDR, 32'hdead_beef);
        read_expect(PRESCALE_ADDR, "prescale", 32'h0000_beef);
        apb_write(PRESCALE_ADDR, 32'(PRESCALE_RESET));
    endtask

    task automatic test_glyph_decoding();
        logic [5:0]  codes [$];
        logic [31:0] rnd;
        logic        dp;
        for (int c = 0; c < 39; c++) begin
            codes.push_back(6'(c));
        end
        codes.push_back(6'd39);
        codes.push_back(6'd47);
        codes.push_back(6'd63);
        foreach (codes[i]) begin
            rnd = $random(seed);
            dp  = rnd[0];
            apb_write(DIGIT_BASE_ADDR, {23'h0, 1'b0, 1'b0, dp, codes[i]});
            apb_write(CTRL_ADDR, 32'h0000_fe01);  // Only digit 0 unblanked.
            wait_digit(0);
            check("seg_n_o", 32'(seg_n), 32'(glyph_pins(codes[i], dp)));
            apb_write(CTRL_ADDR, 32'h0);
        end
    endtask

    task automatic test_raw_mode();
        logic [7:0]  raw [8];
        logic [31:0] rnd;
        for (int d = 1; d < N_DIG; d++) begin
            rnd    = $random(seed);
            raw[d] = rnd[7:0];
            apb_write(DIGIT_BASE_ADDR + 8'(4 * d), {23'h0, 1'b1, raw[d]});
        end
        apb_write(CTRL_ADDR, 32'h0000_0101);
        for (int d = 1; d < N_DIG; d++) begin
            wait_digit(d);
            check("seg_n_o", 32'(seg_n), {24'h0, ~raw[d]});
        end
        apb_write(CTRL_ADDR, 32'h0);
    endtask

    task automatic test_scan_timing();
        int held;
        apb_write(PRESCALE_ADDR, 32'd5);
        apb_write(CTRL_ADDR, 32'h0000_0001);
        wait_digit(0);
        for (int s = 0; s < N_DIG; s++) begin
            held = 0;
            while (an === anode_for(s) && held < 100) begin
                next_cycle();
                held++;
            end
            check("hold cycles", 32'(held), 32'd6);
            check("an_o", 32'(an), 32'(anode_for((s + 1) % N_DIG)));
        end
        apb_write(CTRL_ADDR, 32'h0);
    endtask

    task automatic test_blank_disable();
        logic [31:0] rnd;
        logic [7:0]  mask;
        logic [7:0]  seen;
        logic [7:0]  an_acc;
        logic [7:0]  seg_acc;
        rnd  = $random(seed);
        mask = (rnd[7:0] == 8'hff) ? 8'h7f : rnd[7:0];
        seen = 8'h00;
        apb_write(CTRL_ADDR, {16'h0, mask, 8'h01});
        repeat (60) begin  // One round is 8 digits of 6 cycles.
            seen = seen | ~an;
            next_cycle();
        end
        check("blanked anodes", 32'(seen & mask), 32'h0);
        check("active anodes", 32'(seen), {24'h0, ~mask});
        apb_write(CTRL_ADDR, 32'h0);
        repeat (2) next_cycle();
        an_acc  = 8'hff;
        seg_acc = 8'hff;
        repeat (20) begin
            an_acc  = an_acc & an;
            seg_acc = seg_acc & seg_n;
            next_cycle();
        end
        check("an_o", 32'(an_acc), 32'hff);
        check("seg_n_o", 32'(seg_acc), 32'hff);
    endtask

    // ~~~~~~~~~~~~ Sequence ~~~~~~~~~~~~~~~~~~~
    initial begin
        errors = 0;
        checks = 0;
        seed   = 32'h8e87;
        rst_n  = 1'b0;
        req    = '0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_reset_state();
        test_register_access();
        test_glyph_decoding();
        test_raw_mode();
        test_scan_timing();
        test_blank_disable();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
rtl/seg_pkg.sv
rtl/seg_glyph_decoder.sv
rtl/seg_apb_regs.sv
rtl/seg_scan_mux.sv
rtl/seg_display_top.sv
verif/tb_seg_display.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --timescale 1ns/1ns
TOP       := tb_seg_display
FILELIST  := project.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "tests failed" $(LOG); then \
		echo "Simulation reported failures"; \
		exit 1; \
	fi
	@grep -q "all tests passed" $(LOG) || (echo "No pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
